//--- build.f
+incdir+tests
logic/table_pkg.sv
logic/card_dealer.sv
logic/player_hand.sv
logic/turn_control.sv
logic/round_settle.sv
logic/blackjack_table.sv
tests/tb_blackjack_table.sv

//--- logic/blackjack_table.sv
// ==========================================================
// two-seat card betting table, top level
// bet_up, hit and done are one-cycle pulses per seat
// only one seat can take a card in any cycle
// ==========================================================
`timescale 1ns/100ps

module blackjack_table (
	input  logic                               clk,
	input  logic                               resetn,
	input  logic [table_pkg::NUM_PLAYERS-1:0]  bet_up,
	input  logic [table_pkg::NUM_PLAYERS-1:0]  hit,
	input  logic [table_pkg::NUM_PLAYERS-1:0]  done,
	output table_pkg::phase_t                  phase,
	output logic                               card_valid,
	output table_pkg::card_t                   card_value,
	output table_pkg::money_t                  bet        [table_pkg::NUM_PLAYERS],
	output table_pkg::money_t                  bankroll   [table_pkg::NUM_PLAYERS],
	output table_pkg::hand_t                   hand_total [table_pkg::NUM_PLAYERS],
	output table_pkg::outcome_t                outcome
);

	logic [table_pkg::NUM_PLAYERS-1:0] card_ready;   // one bit per seat

	card_dealer u_dealer (
		.clk        (clk),
		.resetn     (resetn),
		.card_ready (card_ready),
		.card_valid (card_valid),
		.card_value (card_value)
	);

	turn_control u_turn (
		.clk    (clk),
		.resetn (resetn),
		.done   (done),
		.phase  (phase)
	);

	// same seat logic for both players
	for (genvar i = 0; i < table_pkg::NUM_PLAYERS; i++) begin : g_seat
		player_hand #(
			.PLAYER_ID (i)
		) u_hand (
			.clk        (clk),
			.resetn     (resetn),
			.phase      (phase),
			.bet_up     (bet_up[i]),
			.hit        (hit[i]),
			.bankroll   (bankroll[i]),
			.card_valid (card_valid),
			.card_value (card_value),
			.card_ready (card_ready[i]),
			.bet        (bet[i]),
			.hand_total (hand_total[i])
		);
	end

	round_settle u_settle (
		.clk        (clk),
		.resetn     (resetn),
		.phase      (phase),
		.bet        (bet),
		.hand_total (hand_total),
		.bankroll   (bankroll),
		.outcome    (outcome)
	);

endmodule

//--- logic/card_dealer.sv
// ==========================================================
// pseudo-random card source, values 1 to 10
// the sequence repeats; fine for play, not for fair odds
// card is held until a seat accepts it
// ==========================================================
`timescale 1ns/100ps

module card_dealer (
	input  logic                                clk,
	input  logic                                resetn,
	input  logic [table_pkg::NUM_PLAYERS-1:0]   card_ready,
	output logic                                card_valid,
	output table_pkg::card_t                    card_value
);

	logic [table_pkg::LFSR_W-1:0] lfsr;
	logic                         feedback;
	logic                         take;    // card accepted this cycle
	logic [3:0]                   code;

	assign feedback = lfsr[6] ^ lfsr[5];
	assign take     = card_valid & (|card_ready);
	assign code     = lfsr[3:0];

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			lfsr       <= table_pkg::LFSR_SEED;
			card_valid <= 1'b0;
		end else begin
			card_valid <= 1'b1;    // first card ready one cycle after reset
			if (take)
				lfsr <= {lfsr[6:0], feedback};
		end
	end

	// fold the 16 codes onto card values
	always_comb begin
		if (code < 4'd2)
			card_value = table_pkg::card_t'(1);
		else if (code > 4'd9)
			card_value = table_pkg::card_t'(10);   // face cards count as ten
		else
			card_value = table_pkg::card_t'(code);
	end

endmodule

//--- logic/player_hand.sv
// ==========================================================
// one seat: bet register and running hand total
// acts only in its own bet and draw phases
// bet never exceeds MAX_BET or the current bankroll
// both registers clear as the round settles
// ==========================================================
`timescale 1ns/100ps

module player_hand #(
	parameter int PLAYER_ID = 0
) (
	input  logic                  clk,
	input  logic                  resetn,
	input  table_pkg::phase_t     phase,
	input  logic                  bet_up,
	input  logic                  hit,
	input  table_pkg::money_t     bankroll,
	input  logic                  card_valid,
	input  table_pkg::card_t      card_value,
	output logic                  card_ready,
	output table_pkg::money_t     bet,
	output table_pkg::hand_t      hand_total
);

	localparam table_pkg::phase_t BET_PHASE =
		(PLAYER_ID == 0) ? table_pkg::PH_BET_P0 : table_pkg::PH_BET_P1;
	localparam table_pkg::phase_t DRAW_PHASE =
		(PLAYER_ID == 0) ? table_pkg::PH_DRAW_P0 : table_pkg::PH_DRAW_P1;

	logic              my_bet;
	logic              my_draw;
	logic              settle;
	table_pkg::money_t bet_cap;
	table_pkg::money_t bet_next;
	logic              take;

	assign my_bet  = (phase == BET_PHASE);
	assign my_draw = (phase == DRAW_PHASE);
	assign settle  = (phase == table_pkg::PH_SETTLE);

	// cap is the smaller of the table limit and what we can pay
	assign bet_cap = (bankroll < table_pkg::MAX_BET) ? bankroll : table_pkg::MAX_BET;

	always_comb begin
		bet_next = bet + table_pkg::BET_STEP;   // at most 55, no overflow
		if (bet_next > bet_cap)
			bet_next = bet_cap;
	end

	// ask for a card only while hitting and not yet bust
	assign card_ready = my_draw & hit & (hand_total <= table_pkg::BUST_LIMIT);
	assign take       = card_ready & card_valid;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			bet <= '0;
		end else if (settle) begin
			bet <= '0;
		end else if (my_bet && bet_up) begin
			bet <= bet_next;
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			hand_total <= '0;
		end else if (settle) begin
			hand_total <= '0;
		end else if (take) begin
			hand_total <= hand_total + table_pkg::hand_t'(card_value);
		end
	end

endmodule

//--- logic/round_settle.sv
// ==========================================================
// end of round: decide the winner, move the loser's bet
// totals above BUST_LIMIT are bust
// bankrolls always sum to twice START_BANKROLL
// ==========================================================
`timescale 1ns/100ps

module round_settle (
	input  logic                  clk,
	input  logic                  resetn,
	input  table_pkg::phase_t     phase,
	input  table_pkg::money_t     bet        [table_pkg::NUM_PLAYERS],
	input  table_pkg::hand_t      hand_total [table_pkg::NUM_PLAYERS],
	output table_pkg::money_t     bankroll   [table_pkg::NUM_PLAYERS],
	output table_pkg::outcome_t   outcome
);

	logic                bust0;
	logic                bust1;
	table_pkg::outcome_t result;

	assign bust0 = hand_total[0] > table_pkg::BUST_LIMIT;
	assign bust1 = hand_total[1] > table_pkg::BUST_LIMIT;

	always_comb begin
		if (bust0 != bust1) begin
			// only one bust, the other seat takes it
			result = bust0 ? table_pkg::OUT_P1_WINS : table_pkg::OUT_P0_WINS;
		end else if (hand_total[0] == hand_total[1]) begin
			result = table_pkg::OUT_PUSH;
		end else if (bust0) begin
			// both bust: lower total wins
			result = (hand_total[0] < hand_total[1]) ?
				table_pkg::OUT_P0_WINS : table_pkg::OUT_P1_WINS;
		end else begin
			result = (hand_total[0] > hand_total[1]) ?
				table_pkg::OUT_P0_WINS : table_pkg::OUT_P1_WINS;
		end
	end

	// loser pays own bet; bet was capped at the bankroll so no underflow
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			for (int i = 0; i < table_pkg::NUM_PLAYERS; i++)
				bankroll[i] <= table_pkg::START_BANKROLL;
			outcome <= table_pkg::OUT_NONE;
		end else if (phase == table_pkg::PH_SETTLE) begin
			outcome <= result;
			case (result)
				table_pkg::OUT_P0_WINS: begin
					bankroll[0] <= bankroll[0] + bet[1];
					bankroll[1] <= bankroll[1] - bet[1];
				end
				table_pkg::OUT_P1_WINS: begin
					bankroll[1] <= bankroll[1] + bet[0];
					bankroll[0] <= bankroll[0] - bet[0];
				end
				default: begin
					// push, money stays put
				end
			endcase
		end
	end

endmodule

//--- logic/table_pkg.sv
// ==========================================================
// shared widths, constants and types for the card table
// sized for two seats; money fits 8 bits since the total
// in play is fixed at twice the starting bankroll
// ==========================================================
package table_pkg;

	localparam int NUM_PLAYERS = 2;

	localparam int MONEY_W = 8;
	localparam int HAND_W  = 6;   // 21 plus a 10 card still fits
	localparam int CARD_W  = 4;
	localparam int LFSR_W  = 8;

	typedef logic [MONEY_W-1:0] money_t;
	typedef logic [HAND_W-1:0]  hand_t;
	typedef logic [CARD_W-1:0]  card_t;

	// money constants
	localparam money_t START_BANKROLL = money_t'(100);
	localparam money_t BET_STEP       = money_t'(5);
	localparam money_t MAX_BET        = money_t'(50);

	localparam hand_t BUST_LIMIT = hand_t'(21);   // highest total that still counts

	localparam logic [LFSR_W-1:0] LFSR_SEED = LFSR_W'(15);

	// round order, one phase at a time
	typedef enum logic [2:0] {
		PH_BET_P0,
		PH_BET_P1,
		PH_DRAW_P0,
		PH_DRAW_P1,
		PH_SETTLE
	} phase_t;

	// result of the last settled round
	typedef enum logic [1:0] {
		OUT_NONE,      // nothing settled since reset
		OUT_PUSH,
		OUT_P0_WINS,
		OUT_P1_WINS
	} outcome_t;

endpackage

//--- logic/turn_control.sv
// ==========================================================
// round sequencer: bet p0, bet p1, draw p0, draw p1, settle
// each phase waits for the active seat's done pulse
// settle always lasts a single cycle
// ==========================================================
`timescale 1ns/100ps

module turn_control (
	input  logic                               clk,
	input  logic                               resetn,
	input  logic [table_pkg::NUM_PLAYERS-1:0]  done,
	output table_pkg::phase_t                  phase
);

	table_pkg::phase_t phase_next;

	// done from the seat that is not active is ignored
	always_comb begin
		phase_next = phase;
		case (phase)
			table_pkg::PH_BET_P0: begin
				if (done[0])
					phase_next = table_pkg::PH_BET_P1;
			end
			table_pkg::PH_BET_P1: begin
				if (done[1])
					phase_next = table_pkg::PH_DRAW_P0;
			end
			table_pkg::PH_DRAW_P0: begin
				if (done[0])
					phase_next = table_pkg::PH_DRAW_P1;
			end
			table_pkg::PH_DRAW_P1: begin
				if (done[1])
					phase_next = table_pkg::PH_SETTLE;
			end
			table_pkg::PH_SETTLE: begin
				phase_next = table_pkg::PH_BET_P0;   // no wait here
			end
			default: begin
				phase_next = table_pkg::PH_BET_P0;   // unused codes recover
			end
		endcase
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			phase <= table_pkg::PH_BET_P0;
		else
			phase <= phase_next;
	end

endmodule

//--- run.sh
#!/bin/sh
# build the card table testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_blackjack_table -Mdir obj_dir -f build.f

./obj_dir/Vtb_blackjack_table > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Test completed successfully" "$LOG"; then
	exit 0
fi
exit 1

//--- tests/table_model.svh
// ==========================================================
// expected-state tracker included inside the testbench
// reads the testbench's input and card signals directly
// card values are taken from the observed card_value
// ==========================================================
`ifndef TABLE_MODEL_SVH
`define TABLE_MODEL_SVH

table_pkg::phase_t   exp_phase;
table_pkg::money_t   exp_bet   [table_pkg::NUM_PLAYERS];
table_pkg::money_t   exp_bank  [table_pkg::NUM_PLAYERS];
table_pkg::hand_t    exp_total [table_pkg::NUM_PLAYERS];
table_pkg::outcome_t exp_outcome;
logic                exp_valid;
table_pkg::card_t    exp_card;
logic                exp_card_held;   // no transfer at the last edge

function automatic table_pkg::phase_t bet_phase_of(input int seat);
	return (seat == 0) ? table_pkg::PH_BET_P0 : table_pkg::PH_BET_P1;
endfunction

function automatic table_pkg::phase_t draw_phase_of(input int seat);
	return (seat == 0) ? table_pkg::PH_DRAW_P0 : table_pkg::PH_DRAW_P1;
endfunction

// fixed round order
function automatic table_pkg::phase_t following_phase(input table_pkg::phase_t ph);
	case (ph)
		table_pkg::PH_BET_P0:  return table_pkg::PH_BET_P1;
		table_pkg::PH_BET_P1:  return table_pkg::PH_DRAW_P0;
		table_pkg::PH_DRAW_P0: return table_pkg::PH_DRAW_P1;
		table_pkg::PH_DRAW_P1: return table_pkg::PH_SETTLE;
		default:               return table_pkg::PH_BET_P0;
	endcase
endfunction

// winner by the table rule where totals above the limit are bust
function automatic table_pkg::outcome_t settle_result(input int t0, input int t1);
	bit over0;
	bit over1;
	over0 = t0 > int'(table_pkg::BUST_LIMIT);
	over1 = t1 > int'(table_pkg::BUST_LIMIT);
	if (over0 && !over1)
		return table_pkg::OUT_P1_WINS;
	if (over1 && !over0)
		return table_pkg::OUT_P0_WINS;
	if (t0 == t1)
		return table_pkg::OUT_PUSH;
	if (over0)
		return (t0 < t1) ? table_pkg::OUT_P0_WINS : table_pkg::OUT_P1_WINS;   // both bust
	return (t0 > t1) ? table_pkg::OUT_P0_WINS : table_pkg::OUT_P1_WINS;
endfunction

task automatic reset_expected();
	exp_phase = table_pkg::PH_BET_P0;
	for (int p = 0; p < table_pkg::NUM_PLAYERS; p++) begin
		exp_bet[p]   = '0;
		exp_total[p] = '0;
		exp_bank[p]  = table_pkg::START_BANKROLL;
	end
	exp_outcome   = table_pkg::OUT_NONE;
	exp_valid     = 1'b0;
	exp_card      = '0;
	exp_card_held = 1'b0;
endtask

task automatic settle_expected();
	table_pkg::outcome_t res;
	res = settle_result(int'(exp_total[0]), int'(exp_total[1]));
	if (res == table_pkg::OUT_P0_WINS) begin
		exp_bank[0] = exp_bank[0] + exp_bet[1];   // p1 pays its own bet
		exp_bank[1] = exp_bank[1] - exp_bet[1];
	end else if (res == table_pkg::OUT_P1_WINS) begin
		exp_bank[1] = exp_bank[1] + exp_bet[0];
		exp_bank[0] = exp_bank[0] - exp_bet[0];
	end
	exp_outcome = res;
	for (int p = 0; p < table_pkg::NUM_PLAYERS; p++) begin
		exp_bet[p]   = '0;
		exp_total[p] = '0;
	end
	exp_phase = table_pkg::PH_BET_P0;
endtask

// state after the coming rising edge from the inputs held now
task automatic advance_expected();
	int cap;
	int raised;
	int active;
	bit took;
	took = 1'b0;
	if (exp_phase == table_pkg::PH_SETTLE) begin
		settle_expected();
	end else begin
		for (int p = 0; p < table_pkg::NUM_PLAYERS; p++) begin
			if (exp_phase == bet_phase_of(p) && bet_up[p]) begin
				cap = int'(table_pkg::MAX_BET);
				if (int'(exp_bank[p]) < cap)
					cap = int'(exp_bank[p]);
				raised = int'(exp_bet[p]) + int'(table_pkg::BET_STEP);
				if (raised > cap)
					raised = cap;
				exp_bet[p] = table_pkg::money_t'(raised);
			end
			if (exp_phase == draw_phase_of(p) && hit[p] && exp_valid &&
					int'(exp_total[p]) <= int'(table_pkg::BUST_LIMIT)) begin
				exp_total[p] = exp_total[p] + table_pkg::hand_t'(card_value);
				took         = 1'b1;
			end
		end
		if (exp_phase == table_pkg::PH_BET_P0 || exp_phase == table_pkg::PH_DRAW_P0)
			active = 0;
		else
			active = 1;
		if (done[active])
			exp_phase = following_phase(exp_phase);
	end
	exp_card      = card_value;   // dealer holds it unless a seat took it
	exp_card_held = !took;
	exp_valid     = 1'b1;   // dealer has a card from the first edge on
endtask

`endif

//--- tests/tb_blackjack_table.sv
// ==========================================================
// testbench for the two-seat card table
// plays 30 seeded rounds and tracks the expected state per cycle
// outputs sampled on the falling clock edge
// ==========================================================
`timescale 1ns/100ps

module tb_blackjack_table;

	localparam int ROUNDS      = 30;
	localparam int MAX_PRESSES = 12;
	localparam int MAX_HITS    = 6;
	// a pulse and an idle cycle per press over the four turns of a round
	localparam int ROUND_CYCLES = 2 * 2 * (MAX_PRESSES + 1) + 2 * 2 * (MAX_HITS + 1) + 4;
	localparam int MAX_CYCLES   = ROUNDS * ROUND_CYCLES + 480;

	logic                              clk;
	logic                              resetn;
	logic [table_pkg::NUM_PLAYERS-1:0] bet_up;
	logic [table_pkg::NUM_PLAYERS-1:0] hit;
	logic [table_pkg::NUM_PLAYERS-1:0] done;
	table_pkg::phase_t                 phase;
	logic                              card_valid;
	table_pkg::card_t                  card_value;
	table_pkg::money_t                 bet        [table_pkg::NUM_PLAYERS];
	table_pkg::money_t                 bankroll   [table_pkg::NUM_PLAYERS];
	table_pkg::hand_t                  hand_total [table_pkg::NUM_PLAYERS];
	table_pkg::outcome_t               outcome;

	int                errors = 0;
	int                checks = 0;
	int                cycles = 0;
	int                seed;
	table_pkg::phase_t last_phase = table_pkg::PH_BET_P0;

	`include "table_model.svh"

	blackjack_table DUT (
		.clk        (clk),
		.resetn     (resetn),
		.bet_up     (bet_up),
		.hit        (hit),
		.done       (done),
		.phase      (phase),
		.card_valid (card_valid),
		.card_value (card_value),
		.bet        (bet),
		.bankroll   (bankroll),
		.hand_total (hand_total),
		.outcome    (outcome)
	);

	always #4 clk = ~clk;

	task automatic check_value(input string name, input int expv, input int actv);
		checks++;
		assert (actv == expv) else begin
			errors++;
			$display("Fail time=%0t signal=%s expected=%0d actual=%0d",
				$time, name, expv, actv);
		end
	endtask

	task automatic check_outputs();
		int sum;
		check_value("phase", int'(exp_phase), int'(phase));
		check_value("card_valid", int'(exp_valid), int'(card_valid));
		check_value("outcome", int'(exp_outcome), int'(outcome));
		for (int p = 0; p < table_pkg::NUM_PLAYERS; p++) begin
			check_value($sformatf("bet[%0d]", p), int'(exp_bet[p]), int'(bet[p]));
			check_value($sformatf("hand_total[%0d]", p), int'(exp_total[p]),
				int'(hand_total[p]));
			check_value($sformatf("bankroll[%0d]", p), int'(exp_bank[p]), int'(bankroll[p]));
		end
		if (exp_card_held)
			check_value("card_value", int'(exp_card), int'(card_value));
		if (card_valid) begin
			checks++;
			assert (int'(card_value) >= 1 && int'(card_value) <= 10) else begin
				errors++;
				$display("at %0t the dealer shows card %0d, outside 1 to 10",
					$time, card_value);
			end
		end
		sum = int'(bankroll[0]) + int'(bankroll[1]);
		checks++;
		assert (sum == 2 * int'(table_pkg::START_BANKROLL)) else begin
			errors++;
			$display("at %0t the bankrolls add up to %0d, money was lost or made",
				$time, sum);
		end
		// the cycle after settle starts a clean round
		if (last_phase == table_pkg::PH_SETTLE) begin
			checks++;
			assert (phase == table_pkg::PH_BET_P0 && bet[0] == '0 && bet[1] == '0 &&
					hand_total[0] == '0 && hand_total[1] == '0) else begin
				errors++;
				$display("at %0t the round after settle did not start clean", $time);
			end
		end
		last_phase = phase;
	endtask

	// one pulse cycle followed by one idle cycle
	task automatic press_buttons(input logic [1:0] bu, input logic [1:0] h, input logic [1:0] d);
		@(posedge clk);
		#1;
		bet_up = bu;
		hit    = h;
		done   = d;
		@(posedge clk);
		#1;
		bet_up = '0;
		hit    = '0;
		done   = '0;
	endtask

	task automatic wait_for_phase(input table_pkg::phase_t target);
		@(negedge clk);
		while (phase != target)
			@(negedge clk);
	endtask

	// one seat's bet or draw turn with stray presses from the idle seat
	task automatic play_turn(input int seat, input bit drawing);
		int         count;
		int         r;
		logic [1:0] own;
		logic [1:0] other;
		own   = (seat == 0) ? 2'b01 : 2'b10;
		other = ~own;
		if (drawing) begin
			count = $unsigned($random(seed)) % (MAX_HITS + 1);
			wait_for_phase(draw_phase_of(seat));
		end else begin
			count = $unsigned($random(seed)) % (MAX_PRESSES + 1);
			wait_for_phase(bet_phase_of(seat));
		end
		for (int k = 0; k < count; k++) begin
			r = $random(seed);
			if (drawing)
				press_buttons(r[3:2], own | (r[1:0] & other), r[5:4] & other);
			else
				press_buttons(own | (r[1:0] & other), r[3:2], r[5:4] & other);
		end
		press_buttons(2'b00, 2'b00, own);   // hand over the turn
	endtask

	always @(negedge clk) begin
		if (!resetn) begin
			reset_expected();
		end else begin
			check_outputs();
			advance_expected();
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, the rounds did not finish within %0d cycles", MAX_CYCLES);
			$display("errors=%0d checks=%0d", errors, checks);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		clk    = 1'b0;
		resetn = 1'b0;
		bet_up = '0;
		hit    = '0;
		done   = '0;
		seed   = 61;
		reset_expected();
		repeat (2) @(posedge clk);
		#1;
		resetn = 1'b1;
		for (int r = 0; r < ROUNDS; r++) begin
			play_turn(0, 1'b0);
			play_turn(1, 1'b0);
			play_turn(0, 1'b1);
			play_turn(1, 1'b1);
			wait_for_phase(table_pkg::PH_BET_P0);   // settle done
		end
		repeat (2) @(negedge clk);
		#1;
		$display("errors=%0d checks=%0d", errors, checks);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
